/* project.f */
+incdir+rtl
+incdir+testbench
rtl/cpuPkg.sv
rtl/hazardIf.sv
rtl/instDecoder.sv
rtl/regFile.sv
rtl/hazardUnit.sv
rtl/execAlu.sv
rtl/mipsCore.sv
testbench/mipsCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := mipsCoreTb
FILELIST  := project.f
OBJDIR    := obj_dir
LOG       := sim.log
PASS_TEXT := Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* testbench/coreTests.svh */
task automatic aluOps();
    word_t a;
    word_t b;
    startProgram();
    a = nextRandom();
    b = nextRandom();
    lui(5'd1, a[31:16]);
    lui(5'd2, b[31:16]);
    ori(5'd3, 5'd0, a[15:0]);
    ori(5'd1, 5'd1, a[15:0]);
    ori(5'd2, 5'd2, b[15:0]);
    addu(5'd4, 5'd1, 5'd2);
    subu(5'd5, 5'd1, 5'd2);
    subu(5'd6, 5'd2, 5'd1);
    ori(5'd7, 5'd3, b[15:0]);
    runProgram("alu ops");
endtask

// dependent chain with nops that push the producer to write-back
task automatic forwardChain();
    word_t a;
    startProgram();
    a = nextRandom();
    loadConst(5'd8, a);
    addu(5'd9, 5'd8, 5'd8);
    subu(5'd10, 5'd9, 5'd8);
    addu(5'd11, 5'd10, 5'd9);
    place('0);
    ori(5'd12, 5'd11, a[31:16]);
    addu(5'd13, 5'd12, 5'd11);
    place('0);
    place('0);
    subu(5'd14, 5'd13, 5'd12);
    addu(5'd15, 5'd14, 5'd14);
    runProgram("forward chain");
endtask

task automatic loadStore();
    word_t a;
    startProgram();
    a = nextRandom();
    ori(5'd1, 5'd0, 16'h0040);
    loadConst(5'd2, a);
    sw(5'd2, 5'd1, 16'h0000);
    sw(5'd2, 5'd1, 16'hfffc);
    // load-use on the next instruction
    lw(5'd3, 5'd1, 16'h0000);
    addu(5'd4, 5'd3, 5'd2);
    // loaded word stored right away
    lw(5'd5, 5'd1, 16'h0004);
    sw(5'd5, 5'd1, 16'h000c);
    lw(5'd6, 5'd1, 16'h000c);
    sw(5'd4, 5'd1, 16'h0010);
    lw(5'd7, 5'd0, 16'h0020);
    subu(5'd8, 5'd7, 5'd6);
    runProgram("load store");
endtask

task automatic branches();
    word_t a;
    startProgram();
    a = nextRandom();
    loadConst(5'd1, {a[31:16] | 16'h0100, a[15:0]});
    lui(5'd3, ~a[31:16]);
    ori(5'd2, 5'd1, 16'h0000);
    // taken while r2 is still in execute
    beq(5'd1, 5'd2, 16'd3);
    addu(5'd4, 5'd1, 5'd3);
    place(iType(`OP_ORI, 5'd5, 5'd0, 16'h1111));
    place(iType(`OP_ORI, 5'd6, 5'd0, 16'h2222));
    ori(5'd7, 5'd0, 16'h3333);
    beq(5'd1, 5'd3, 16'd3);
    ori(5'd8, 5'd0, 16'h4444);
    ori(5'd9, 5'd1, 16'h5555);
    // taken on a load still in execute
    loadConst(5'd17, refMem[0]);
    lw(5'd10, 5'd0, 16'h0000);
    beq(5'd10, 5'd17, 16'd2);
    addu(5'd11, 5'd10, 5'd1);
    place(iType(`OP_ORI, 5'd12, 5'd0, 16'h6666));
    ori(5'd13, 5'd11, 16'h7777);
    // not taken with its operand still in the ALU
    addu(5'd14, 5'd1, 5'd3);
    beq(5'd14, 5'd3, 16'd2);
    subu(5'd15, 5'd14, 5'd1);
    ori(5'd16, 5'd0, 16'h8888);
    runProgram("branches");
endtask

task automatic jumpAndZero();
    startProgram();
    ori(5'd1, 5'd0, 16'h0001);
    jump(progLen + 4);
    ori(5'd2, 5'd0, 16'h0002);
    place(iType(`OP_ORI, 5'd3, 5'd0, 16'h0003));
    place(iType(`OP_ORI, 5'd4, 5'd0, 16'h0004));
    // writes to r0 leave no trace
    addu(5'd0, 5'd1, 5'd2);
    ori(5'd0, 5'd0, 16'h0005);
    lui(5'd0, 16'hbeef);
    addu(5'd5, 5'd0, 5'd1);
    runProgram("jump and zero");
endtask

/* testbench/mipsCoreTb.sv */
`timescale 1ns/1ps
`include "cpuSettings.svh"

module mipsCoreTb;
    import cpuPkg::*;

    localparam int CLK_PERIOD      = 4;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;

    logic     clk;
    logic     reset;
    word_t    instData;
    word_t    dataRdata;
    word_t    instAddr;
    word_t    dataAddr;
    word_t    dataWdata;
    logic     dataWe;
    logic     wbWe;
    regAddr_t wbAddr;
    word_t    wbData;
    word_t    wbPc;

    word_t       instMem [256];
    word_t       dataMem [256];
    logic [7:0]  instIdx;

    // reference state of the ISA model
    word_t       refMem [256];
    word_t       refRegs [`REG_COUNT];
    int          progLen;
    logic [31:0] rngState;

    logic        collect;
    regAddr_t    gotAddr [$];
    word_t       gotData [$];
    word_t       gotPc [$];
    time         gotTime [$];
    regAddr_t    expAddr [$];
    word_t       expData [$];
    word_t       expPc [$];
    int          valueErrors;
    int          traceErrors;

    mipsCore mipsCore_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // memories answer within the cycle
    assign instIdx   = 8'((instAddr - `PC_INIT) >> 2);
    assign instData  = instMem[instIdx];
    assign dataRdata = dataMem[dataAddr[9:2]];

    always @(posedge clk) begin
        if (dataWe) begin
            dataMem[dataAddr[9:2]] <= dataWdata;
        end
    end

    always @(negedge clk) begin
        if (collect && !reset && wbWe) begin
            gotAddr.push_back(wbAddr);
            gotData.push_back(wbData);
            gotPc.push_back(wbPc);
            gotTime.push_back($time);
        end
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic word_t fillWord(int idx);
        return 32'hC0DE_0000 ^ (32'(idx) * 32'h0001_0101);
    endfunction

    function automatic word_t slotPc(int idx);
        return `PC_INIT + 32'(idx) * 32'd4;
    endfunction

    function automatic word_t rType(logic [5:0] funct, regAddr_t rd, regAddr_t rs, regAddr_t rt);
        return {`OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t iType(logic [5:0] op, regAddr_t rt, regAddr_t rs, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic checkWord(string name, word_t got, word_t exp, time at);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h, expected %h", at, name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkReg(string name, regAddr_t got, regAddr_t exp, time at);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d, expected %0d", at, name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic checkPc(string name, word_t got, word_t exp, time at);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h, expected %h", at, name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic place(word_t instr);
        instMem[progLen] = instr;
        progLen++;
    endtask

    // write-back expected from the instruction placed last
    task automatic retire(regAddr_t r, word_t value);
        if (r != '0) begin
            refRegs[r] = value;
            expAddr.push_back(r);
            expData.push_back(value);
            expPc.push_back(slotPc(progLen - 1));
        end
    endtask

    task automatic lui(regAddr_t rt, logic [15:0] imm);
        place(iType(`OP_LUI, rt, 5'd0, imm));
        retire(rt, {imm, 16'h0000});
    endtask

    task automatic ori(regAddr_t rt, regAddr_t rs, logic [15:0] imm);
        place(iType(`OP_ORI, rt, rs, imm));
        retire(rt, refRegs[rs] | {16'h0000, imm});
    endtask

    task automatic addu(regAddr_t rd, regAddr_t rs, regAddr_t rt);
        place(rType(`FUNCT_ADDU, rd, rs, rt));
        retire(rd, refRegs[rs] + refRegs[rt]);
    endtask

    task automatic subu(regAddr_t rd, regAddr_t rs, regAddr_t rt);
        place(rType(`FUNCT_SUBU, rd, rs, rt));
        retire(rd, refRegs[rs] - refRegs[rt]);
    endtask

    task automatic lw(regAddr_t rt, regAddr_t base, logic [15:0] offset);
        word_t addr;
        addr = refRegs[base] + {{16{offset[15]}}, offset};
        place(iType(`OP_LW, rt, base, offset));
        retire(rt, refMem[addr[9:2]]);
    endtask

    task automatic sw(regAddr_t rt, regAddr_t base, logic [15:0] offset);
        word_t addr;
        addr = refRegs[base] + {{16{offset[15]}}, offset};
        place(iType(`OP_SW, rt, base, offset));
        refMem[addr[9:2]] = refRegs[rt];
    endtask

    task automatic beq(regAddr_t rs, regAddr_t rt, logic [15:0] offset);
        place(iType(`OP_BEQ, rt, rs, offset));
    endtask

    task automatic jump(int targetIdx);
        word_t target;
        target = slotPc(targetIdx);
        place({`OP_J, target[27:2]});
    endtask

    task automatic loadConst(regAddr_t r, word_t value);
        lui(r, value[31:16]);
        ori(r, r, value[15:0]);
    endtask

    // holds reset while a new program is loaded
    task automatic startProgram();
        int i;
        @(posedge clk);
        #1;
        reset   = 1'b1;
        collect = 1'b0;
        progLen = 0;
        for (i = 0; i < 256; i++) begin
            instMem[i] = '0;
            dataMem[i] = fillWord(i);
            refMem[i]  = fillWord(i);
        end
        for (i = 0; i < `REG_COUNT; i++) begin
            refRegs[i] = '0;
        end
        gotAddr.delete();
        gotData.delete();
        gotPc.delete();
        gotTime.delete();
        expAddr.delete();
        expData.delete();
        expPc.delete();
    endtask

    task automatic runProgram(string name);
        word_t doneAddr;
        int    cycles;
        int    n;
        int    i;
        repeat (2) @(posedge clk);
        #1;
        reset   = 1'b0;
        collect = 1'b1;
        // fetch well past the last instruction means the pipeline has drained
        doneAddr = slotPc(progLen + 6);
        cycles   = 0;
        while (instAddr !== doneAddr && cycles < CYCLES_PER_TEST) begin
            @(negedge clk);
            cycles++;
        end
        @(negedge clk);
        collect = 1'b0;
        if (cycles >= CYCLES_PER_TEST) begin
            $display("ERROR: %s never fetched past the end of its program", name);
            traceErrors++;
        end
        if (gotAddr.size() < expAddr.size()) begin
            $display("ERROR: %s is missing write-backs, saw %0d of %0d", name,
                     gotAddr.size(), expAddr.size());
            traceErrors++;
        end else if (gotAddr.size() > expAddr.size()) begin
            $display("ERROR: %s has extra write-backs, saw %0d instead of %0d", name,
                     gotAddr.size(), expAddr.size());
            traceErrors++;
        end
        n = (gotAddr.size() < expAddr.size()) ? gotAddr.size() : expAddr.size();
        for (i = 0; i < n; i++) begin
            checkReg($sformatf("%s wbAddr[%0d]", name, i), gotAddr[i], expAddr[i], gotTime[i]);
            checkWord($sformatf("%s wbData[%0d]", name, i), gotData[i], expData[i], gotTime[i]);
            checkPc($sformatf("%s wbPc[%0d]", name, i), gotPc[i], expPc[i], gotTime[i]);
        end
        for (i = 0; i < 256; i++) begin
            checkWord($sformatf("%s dataMem[%0d]", name, i), dataMem[i], refMem[i], $time);
        end
    endtask

    `include "coreTests.svh"

    initial begin
        #(CLK_PERIOD * CYCLES_PER_TEST * NUM_TESTS);
        $display("ERROR: watchdog expired before the tests completed");
        $display("Verification failed");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        collect     = 1'b0;
        progLen     = 0;
        rngState    = 32'd44;
        valueErrors = 0;
        traceErrors = 0;
        for (int i = 0; i < 256; i++) begin
            instMem[i] = '0;
            dataMem[i] = fillWord(i);
        end
        aluOps();
        forwardChain();
        loadStore();
        branches();
        jumpAndZero();
        $display("errors: %0d value, %0d trace", valueErrors, traceErrors);
        if (valueErrors == 0 && traceErrors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* rtl/mipsCore.sv */
`timescale 1ns/1ps
`include "cpuSettings.svh"

module mipsCore (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::word_t    instData,
    input  cpuPkg::word_t    dataRdata,
    output cpuPkg::word_t    instAddr,
    output cpuPkg::word_t    dataAddr,
    output cpuPkg::word_t    dataWdata,
    output logic             dataWe,
    output logic             wbWe,
    output cpuPkg::regAddr_t wbAddr,
    output cpuPkg::word_t    wbData,
    output cpuPkg::word_t    wbPc
);
    import cpuPkg::*;

    word_t       pcF;
    word_t       pcNext;

    word_t       decInstr;
    word_t       decPc;
    word_t       decPcPlus4;
    logic        decValid;
    ctrl_t       decCtrl;
    regAddr_t    decRs;
    regAddr_t    decRt;
    regAddr_t    decDest;
    logic [15:0] decImm;
    word_t       decRegA;
    word_t       decRegB;
    word_t       decOpA;
    word_t       decOpB;

    ctrl_t       exeCtrl;
    word_t       exePc;
    logic        exeValid;
    regAddr_t    exeRs;
    regAddr_t    exeRt;
    regAddr_t    exeDest;
    logic [15:0] exeImm;
    word_t       exeRegA;
    word_t       exeRegB;
    word_t       exeOpA;
    word_t       exeOpB;
    word_t       exeResult;

    ctrl_t       memCtrl;
    word_t       memPc;
    logic        memValid;
    regAddr_t    memRt;
    regAddr_t    memDest;
    word_t       memAluOut;
    word_t       memStoreData;

    ctrl_t       wbCtrl;
    word_t       wbAluOut;
    word_t       wbMemData;

    hazardIf hz (
        .clk   (clk),
        .reset (reset)
    );

    function automatic word_t fwdMux(fwdSel_t sel, word_t regVal, word_t wbVal,
                                     word_t memVal);
        case (sel)
            fwdWb:   return wbVal;
            fwdMem:  return memVal;
            default: return regVal;
        endcase
    endfunction

    // fetch
    assign instAddr = pcF;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pcF <= `PC_INIT;
        end else if (!hz.stall) begin
            pcF <= pcNext;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            decInstr <= '0;
            decPc    <= '0;
            decValid <= 1'b0;
        end else if (!hz.stall) begin
            decInstr <= instData;
            decPc    <= pcF;
            decValid <= 1'b1;
        end
    end

    // decode
    instDecoder decoder_i (
        .instr (decInstr),
        .ctrl  (decCtrl),
        .rs    (decRs),
        .rt    (decRt),
        .dest  (decDest),
        .imm   (decImm)
    );

    regFile regFile_i (
        .clk       (clk),
        .reset     (reset),
        .readAddrA (decRs),
        .readAddrB (decRt),
        .writeAddr (wbAddr),
        .writeData (wbData),
        .writeEn   (wbWe),
        .readDataA (decRegA),
        .readDataB (decRegB)
    );

    assign decOpA     = fwdMux(hz.fwdRsDec, decRegA, wbData, memAluOut);
    assign decOpB     = fwdMux(hz.fwdRtDec, decRegB, wbData, memAluOut);
    assign decPcPlus4 = decPc + 32'd4;

    // fetch already holds the delay slot, so the target follows it
    always_comb begin
        pcNext = pcF + 32'd4;
        if (decCtrl.isJump) begin
            pcNext = {decPcPlus4[31:28], decInstr[25:0], 2'b00};
        end else if (decCtrl.isBranch && decOpA == decOpB) begin
            pcNext = decPcPlus4 + {{14{decImm[15]}}, decImm, 2'b00};
        end
    end

    // stall leaves a bubble in execute
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exeCtrl  <= '0;
            exePc    <= '0;
            exeValid <= 1'b0;
            exeRs    <= '0;
            exeRt    <= '0;
            exeDest  <= '0;
            exeImm   <= '0;
            exeRegA  <= '0;
            exeRegB  <= '0;
        end else begin
            exeCtrl  <= hz.stall ? ctrl_t'('0) : decCtrl;
            exePc    <= decPc;
            exeValid <= decValid && !hz.stall;
            exeRs    <= decRs;
            exeRt    <= decRt;
            exeDest  <= decDest;
            exeImm   <= decImm;
            exeRegA  <= decOpA;
            exeRegB  <= decOpB;
        end
    end

    // execute
    assign exeOpA = fwdMux(hz.fwdRsExe, exeRegA, wbData, memAluOut);
    assign exeOpB = fwdMux(hz.fwdRtExe, exeRegB, wbData, memAluOut);

    execAlu alu_i (
        .aluOp     (exeCtrl.aluOp),
        .aluSrcImm (exeCtrl.aluSrcImm),
        .signExt   (exeCtrl.signExt),
        .srcA      (exeOpA),
        .regB      (exeOpB),
        .imm       (exeImm),
        .result    (exeResult)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memCtrl      <= '0;
            memPc        <= '0;
            memValid     <= 1'b0;
            memRt        <= '0;
            memDest      <= '0;
            memAluOut    <= '0;
            memStoreData <= '0;
        end else begin
            memCtrl      <= exeCtrl;
            memPc        <= exePc;
            memValid     <= exeValid;
            memRt        <= exeRt;
            memDest      <= exeDest;
            memAluOut    <= exeResult;
            memStoreData <= exeOpB;
        end
    end

    // memory
    assign dataAddr  = memAluOut;
    assign dataWdata = (hz.fwdRtMem == fwdWb) ? wbData : memStoreData;
    assign dataWe    = memCtrl.memWrite;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wbCtrl    <= '0;
            wbPc      <= '0;
            wbAddr    <= '0;
            wbAluOut  <= '0;
            wbMemData <= '0;
        end else begin
            wbCtrl    <= memCtrl;
            wbPc      <= memPc;
            wbAddr    <= memDest;
            wbAluOut  <= memAluOut;
            wbMemData <= dataRdata;
        end
    end

    // write-back
    assign wbWe   = wbCtrl.regWrite;
    assign wbData = wbCtrl.memToReg ? wbMemData : wbAluOut;

    assign hz.decRs       = decRs;
    assign hz.decRt       = decRt;
    assign hz.decUseRs    = decCtrl.useRs;
    assign hz.decUseRt    = decCtrl.useRt;
    assign hz.exeRs       = exeRs;
    assign hz.exeRt       = exeRt;
    assign hz.exeDest     = exeDest;
    assign hz.exeNewTime  = exeCtrl.newTime;
    assign hz.exeRegWrite = exeCtrl.regWrite;
    assign hz.memRt       = memRt;
    assign hz.memDest     = memDest;
    // one cycle closer than in execute
    assign hz.memNewTime  = (memCtrl.newTime != '0) ? memCtrl.newTime - 2'd1 : 2'd0;
    assign hz.memRegWrite = memCtrl.regWrite;
    assign hz.wbDest      = wbAddr;
    assign hz.wbRegWrite  = wbWe;

    hazardUnit hazard_i (
        .hz (hz)
    );

    noZeroWrite: assert property (@(posedge clk) disable iff (reset)
        wbWe |-> wbAddr != '0);

    noBubbleStore: assert property (@(posedge clk) disable iff (reset)
        !memValid |-> !dataWe);

endmodule

/* rtl/execAlu.sv */
`timescale 1ns/1ps
`include "cpuSettings.svh"

module execAlu (
    input  cpuPkg::aluOp_t aluOp,
    input  logic           aluSrcImm,
    input  logic           signExt,
    input  cpuPkg::word_t  srcA,
    input  cpuPkg::word_t  regB,
    input  logic [15:0]    imm,
    output cpuPkg::word_t  result
);
    import cpuPkg::*;

    word_t immExt;
    word_t srcB;

    assign immExt = signExt ? {{(`DATA_WIDTH-16){imm[15]}}, imm}
                            : {{(`DATA_WIDTH-16){1'b0}}, imm};
    assign srcB   = aluSrcImm ? immExt : regB;

    always_comb begin
        case (aluOp)
            aluSub:  result = srcA - srcB;
            aluOr:   result = srcA | srcB;
            // low half of the immediate into the upper half
            aluLui:  result = {srcB[15:0], {(`DATA_WIDTH-16){1'b0}}};
            default: result = srcA + srcB;
        endcase
    end

endmodule

/* rtl/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
    hazardIf.unit hz
);
    import cpuPkg::*;

    logic stallRs;
    logic stallRt;
    logic memReady;

    function automatic logic hits(regAddr_t src, regAddr_t dest, logic regWrite);
        return regWrite && dest != '0 && dest == src;
    endfunction

    function automatic logic mustWait(regAddr_t src, stageTime_t useTime, regAddr_t dest,
                                      stageTime_t newTime, logic regWrite);
        return hits(src, dest, regWrite) && useTime < newTime;
    endfunction

    // youngest ready producer wins
    function automatic fwdSel_t pick(regAddr_t src, regAddr_t memDest, logic memOk,
                                     regAddr_t wbDest, logic wbOk);
        if (hits(src, memDest, memOk)) begin
            return fwdMem;
        end
        if (hits(src, wbDest, wbOk)) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    // a load in memory has no data yet
    assign memReady = hz.memRegWrite && hz.memNewTime == '0;

    assign stallRs = mustWait(hz.decRs, hz.decUseRs, hz.exeDest, hz.exeNewTime, hz.exeRegWrite)
                  || mustWait(hz.decRs, hz.decUseRs, hz.memDest, hz.memNewTime, hz.memRegWrite);
    assign stallRt = mustWait(hz.decRt, hz.decUseRt, hz.exeDest, hz.exeNewTime, hz.exeRegWrite)
                  || mustWait(hz.decRt, hz.decUseRt, hz.memDest, hz.memNewTime, hz.memRegWrite);
    assign hz.stall = stallRs || stallRt;

    assign hz.fwdRsDec = pick(hz.decRs, hz.memDest, memReady, hz.wbDest, hz.wbRegWrite);
    assign hz.fwdRtDec = pick(hz.decRt, hz.memDest, memReady, hz.wbDest, hz.wbRegWrite);
    assign hz.fwdRsExe = pick(hz.exeRs, hz.memDest, memReady, hz.wbDest, hz.wbRegWrite);
    assign hz.fwdRtExe = pick(hz.exeRt, hz.memDest, memReady, hz.wbDest, hz.wbRegWrite);
    assign hz.fwdRtMem = hits(hz.memRt, hz.wbDest, hz.wbRegWrite) ? fwdWb : fwdReg;

    // producer left execute with at most one cycle to go
    memFwdReady: assert property (@(posedge hz.clk) disable iff (hz.reset)
        (hz.fwdRsDec == fwdMem || hz.fwdRtDec == fwdMem ||
         hz.fwdRsExe == fwdMem || hz.fwdRtExe == fwdMem)
        |-> ($past(hz.exeRegWrite) && $past(hz.exeNewTime) <= 2'd1));

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps
`include "cpuSettings.svh"

module regFile (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::regAddr_t readAddrA,
    input  cpuPkg::regAddr_t readAddrB,
    input  cpuPkg::regAddr_t writeAddr,
    input  cpuPkg::word_t    writeData,
    input  logic             writeEn,
    output cpuPkg::word_t    readDataA,
    output cpuPkg::word_t    readDataB
);
    import cpuPkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // same-cycle write is not visible here, write-back forwarding covers it
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

/* rtl/instDecoder.sv */
`timescale 1ns/1ps
`include "cpuSettings.svh"

module instDecoder (
    input  cpuPkg::word_t    instr,
    output cpuPkg::ctrl_t    ctrl,
    output cpuPkg::regAddr_t rs,
    output cpuPkg::regAddr_t rt,
    output cpuPkg::regAddr_t dest,
    output logic [15:0]      imm
);
    import cpuPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddr_t   rd;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign imm    = instr[15:0];

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = aluAdd;
        ctrl.useRs = `TIME_NEVER;
        ctrl.useRt = `TIME_NEVER;
        case (opcode)
            `OP_SPECIAL: begin
                if (funct == `FUNCT_ADDU || funct == `FUNCT_SUBU) begin
                    ctrl.aluOp    = (funct == `FUNCT_SUBU) ? aluSub : aluAdd;
                    ctrl.regWrite = 1'b1;
                    ctrl.destIsRd = 1'b1;
                    ctrl.useRs    = 2'd1;
                    ctrl.useRt    = 2'd1;
                    ctrl.newTime  = 2'd1;
                end
            end
            `OP_ORI: begin
                ctrl.aluOp     = aluOr;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.useRs     = 2'd1;
                ctrl.newTime   = 2'd1;
            end
            `OP_LUI: begin
                ctrl.aluOp     = aluLui;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.newTime   = 2'd1;
            end
            `OP_LW: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.signExt   = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.useRs     = 2'd1;
                // data only after the memory stage
                ctrl.newTime   = 2'd2;
            end
            `OP_SW: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.signExt   = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.useRs     = 2'd1;
                ctrl.useRt     = 2'd2;
            end
            `OP_BEQ: begin
                // compared in decode
                ctrl.isBranch = 1'b1;
                ctrl.useRs    = 2'd0;
                ctrl.useRt    = 2'd0;
            end
            `OP_J: begin
                ctrl.isJump = 1'b1;
            end
            default: begin
            end
        endcase
        dest = ctrl.destIsRd ? rd : rt;
        // $zero is never written
        if (dest == '0) begin
            ctrl.regWrite = 1'b0;
        end
    end

endmodule

/* rtl/hazardIf.sv */
`timescale 1ns/1ps

interface hazardIf (
    input logic clk,
    input logic reset
);
    import cpuPkg::*;

    regAddr_t   decRs;
    regAddr_t   decRt;
    stageTime_t decUseRs;
    stageTime_t decUseRt;

    regAddr_t   exeRs;
    regAddr_t   exeRt;
    regAddr_t   exeDest;
    stageTime_t exeNewTime;
    logic       exeRegWrite;

    regAddr_t   memRt;
    regAddr_t   memDest;
    stageTime_t memNewTime;
    logic       memRegWrite;

    regAddr_t   wbDest;
    logic       wbRegWrite;

    logic       stall;
    fwdSel_t    fwdRsDec;
    fwdSel_t    fwdRtDec;
    fwdSel_t    fwdRsExe;
    fwdSel_t    fwdRtExe;
    fwdSel_t    fwdRtMem;

    modport core (
        output decRs, decRt, decUseRs, decUseRt,
        output exeRs, exeRt, exeDest, exeNewTime, exeRegWrite,
        output memRt, memDest, memNewTime, memRegWrite,
        output wbDest, wbRegWrite,
        input  stall, fwdRsDec, fwdRtDec, fwdRsExe, fwdRtExe, fwdRtMem
    );

    modport unit (
        input  clk, reset,
        input  decRs, decRt, decUseRs, decUseRt,
        input  exeRs, exeRt, exeDest, exeNewTime, exeRegWrite,
        input  memRt, memDest, memNewTime, memRegWrite,
        input  wbDest, wbRegWrite,
        output stall, fwdRsDec, fwdRtDec, fwdRsExe, fwdRtExe, fwdRtMem
    );

endinterface

/* rtl/cpuPkg.sv */
`include "cpuSettings.svh"

package cpuPkg;

    typedef logic [`DATA_WIDTH-1:0]     word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddr_t;

    // cycles until an operand is needed or a result is ready
    typedef logic [1:0] stageTime_t;

    typedef enum logic [1:0] {
        aluAdd,
        aluSub,
        aluOr,
        aluLui
    } aluOp_t;

    // source of a forwarded operand
    typedef enum logic [1:0] {
        fwdReg,
        fwdWb,
        fwdMem
    } fwdSel_t;

    typedef struct packed {
        aluOp_t     aluOp;
        logic       aluSrcImm;
        logic       signExt;
        logic       regWrite;
        logic       memWrite;
        logic       memToReg;
        logic       destIsRd;
        logic       isBranch;
        logic       isJump;
        // counted from decode
        stageTime_t useRs;
        stageTime_t useRt;
        // counted from execute
        stageTime_t newTime;
    } ctrl_t;

endpackage

/* rtl/cpuSettings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define DATA_WIDTH     32
`define REG_ADDR_WIDTH 5
`define REG_COUNT      32
`define PC_INIT        32'h0000_3000

// use time of an operand the instruction never reads
`define TIME_NEVER     2'd3

// primary opcodes
`define OP_SPECIAL     6'b000000
`define OP_ORI         6'b001101
`define OP_LUI         6'b001111
`define OP_LW          6'b100011
`define OP_SW          6'b101011
`define OP_BEQ         6'b000100
`define OP_J           6'b000010

// funct field under OP_SPECIAL
`define FUNCT_ADDU     6'b100001
`define FUNCT_SUBU     6'b100011

`endif
